/* Bender.yml */
package:
  name: mod_adder

sources:
  # package first, then the arithmetic units and the pipeline
  - files:
      - rtl/mod_add_pkg.sv
      - rtl/kyber_lane_pair.sv
      - rtl/dilithium_add.sv
      - rtl/mod_add_pipe.sv
      - rtl/mod_adder.sv

  # testbench with its reference header
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mod_adder_tb.sv

/* mod_adder.f */
+incdir+include
rtl/mod_add_pkg.sv
rtl/kyber_lane_pair.sv
rtl/dilithium_add.sv
rtl/mod_add_pipe.sv
rtl/mod_adder.sv
sim/mod_adder_tb.sv

/* rtl/dilithium_add.sv */
`timescale 1ns/100ps
`default_nettype none

module dilithium_add (
    input  mod_add_pkg::dcoef_t a,
    input  mod_add_pkg::dcoef_t b,
    output mod_add_pkg::dcoef_t d_sum
);

    // low half with its carry out
    logic                  lo_c;
    mod_add_pkg::coef_t    lo_s;

    // high half plus low carry
    logic [mod_add_pkg::coef_w:0] hi_s;

    // full 25-bit sum
    logic [mod_add_pkg::word_w:0] sum;

    // trial subtract with an extra borrow bit
    logic [mod_add_pkg::word_w+1:0] trial;
    logic                           keep_red;

    // carry chain split at 12 bits
    assign {lo_c, lo_s} = {1'b0, a[mod_add_pkg::coef_w-1:0]}
                        + {1'b0, b[mod_add_pkg::coef_w-1:0]};

    // upper halves take the low carry in
    assign hi_s = {1'b0, a[mod_add_pkg::word_w-1:mod_add_pkg::coef_w]}
                + {1'b0, b[mod_add_pkg::word_w-1:mod_add_pkg::coef_w]}
                + {{mod_add_pkg::coef_w{1'b0}}, lo_c};

    // join the halves
    assign sum = {hi_s, lo_s};

    // sum minus q
    assign trial = {1'b0, sum} - {2'b00, mod_add_pkg::dil_q};

    // reduce when the trial did not borrow
    assign keep_red = ~trial[mod_add_pkg::word_w+1];

    // in-range operands need at most one subtract of q
    assign d_sum = keep_red ? trial[mod_add_pkg::word_w-1:0]
                            : sum[mod_add_pkg::word_w-1:0];

endmodule

`default_nettype wire

/* rtl/kyber_lane_pair.sv */
`timescale 1ns/100ps
`default_nettype none

module kyber_lane_pair (
    input  mod_add_pkg::add_req_t s1_req,
    output mod_add_pkg::add_rsp_t k_rsp
);

    // cross mode steers operands and result halves
    logic cross_sel;

    // adder lane operands
    mod_add_pkg::coef_t add_x;
    mod_add_pkg::coef_t add_y;
    // subtractor lane operands
    mod_add_pkg::coef_t sub_x;
    mod_add_pkg::coef_t sub_y;

    // adder lane internals
    logic               add_c;
    mod_add_pkg::coef_t add_s;
    logic               add_b;
    mod_add_pkg::coef_t add_d;
    logic               add_keep;
    mod_add_pkg::coef_t add_r;

    // subtractor lane internals
    logic               sub_b;
    mod_add_pkg::coef_t sub_s;
    mod_add_pkg::coef_t sub_r;

    assign cross_sel = (s1_req.mode == mod_add_pkg::mode_k_cross);

    // operand steering
    always_comb begin
        if (cross_sel) begin
            // low halves added
            add_x = s1_req.a.kyber.lo;
            add_y = s1_req.b.kyber.lo;
            // high halves b minus a
            sub_x = s1_req.b.kyber.hi;
            sub_y = s1_req.a.kyber.hi;
        end else begin
            // butterfly on the two halves of a
            add_x = s1_req.a.kyber.hi;
            add_y = s1_req.a.kyber.lo;
            sub_x = s1_req.a.kyber.hi;
            sub_y = s1_req.a.kyber.lo;
        end
    end

    // 13-bit sum then trial subtract of q
    assign {add_c, add_s} = {1'b0, add_x} + {1'b0, add_y};
    assign {add_b, add_d} = {1'b0, add_s} - {1'b0, mod_add_pkg::kyber_q};

    // sum below q only when no carry and the trial borrowed
    assign add_keep = ~(~add_c & add_b);
    assign add_r    = add_keep ? add_d : add_s;

    // difference wraps by adding q back on borrow
    assign {sub_b, sub_s} = {1'b0, sub_x} - {1'b0, sub_y};
    assign sub_r          = sub_s + (sub_b ? mod_add_pkg::kyber_q : '0);

    // result packing
    always_comb begin
        if (cross_sel) begin
            // subtract lands in the hi half
            k_rsp.kyber.hi = sub_r;
            k_rsp.kyber.lo = add_r;
        end else begin
            k_rsp.kyber.hi = add_r;
            k_rsp.kyber.lo = sub_r;
        end
    end

endmodule

`default_nettype wire

/* rtl/mod_add_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module mod_add_pipe (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mod_add_pkg::add_req_t req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output mod_add_pkg::add_req_t s1_req,
    input  mod_add_pkg::add_rsp_t k_rsp,
    input  mod_add_pkg::dcoef_t   d_sum,
    output mod_add_pkg::add_rsp_t rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_ready
);

    // stage 1 occupancy
    logic s1_valid;

    // stage 2 can take a new beat this edge
    logic s2_free;
    // stage 1 content moves into stage 2
    logic s1_move;
    // request handshake this edge
    logic req_take;

    // result chosen by the stage 1 mode
    mod_add_pkg::add_rsp_t sel_rsp;

    // stage 2 empties or drains on this edge
    assign s2_free = ~rsp_valid | rsp_ready;
    assign s1_move = s1_valid & s2_free;

    // room when stage 1 is empty or leaving
    assign req_ready = ~s1_valid | s2_free;
    assign req_take  = req_valid & req_ready;

    // stage 1 request register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_req   <= '0;
        end else begin
            if (req_take) begin
                s1_valid <= 1'b1;
                s1_req   <= req;
            end else if (s1_move) begin
                // drained without refill
                s1_valid <= 1'b0;
            end
        end
    end

    // result select
    always_comb begin
        sel_rsp = k_rsp;
        case (s1_req.mode)
            // both dilithium codes take the 24-bit sum
            mod_add_pkg::mode_d_add,
            mod_add_pkg::mode_d_alt: begin
                sel_rsp.dil = d_sum;
            end
            default: begin
                sel_rsp = k_rsp;
            end
        endcase
    end

    // stage 2 result register
    // holds while rsp_valid is high and rsp_ready low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else if (s2_free) begin
            rsp_valid <= s1_valid;
            if (s1_move) begin
                rsp <= sel_rsp;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mod_add_pkg.sv */
`default_nettype none

package mod_add_pkg;

    // datapath widths
    // one kyber coefficient is half of the operand word
    localparam int coef_w = 12;
    localparam int word_w = 24;

    // moduli
    // sized so a leading zero gives the borrow bit directly
    localparam logic [coef_w-1:0] kyber_q = 12'd3329;
    localparam logic [word_w-1:0] dil_q   = 24'd8380417;

    // single coefficients
    typedef logic [coef_w-1:0] coef_t;
    typedef logic [word_w-1:0] dcoef_t;

    // operation select
    // mode_d_alt behaves exactly like mode_d_add
    typedef enum logic [1:0] {
        mode_k_bfly  = 2'd0,
        mode_k_cross = 2'd1,
        mode_d_add   = 2'd2,
        mode_d_alt   = 2'd3
    } add_mode_e;

    // two kyber coefficients packed in one word
    // hi sits in the upper 12 bits
    typedef struct packed {
        coef_t hi;
        coef_t lo;
    } kyber_pair_t;

    // one 24-bit word seen as kyber pair or as dilithium coefficient
    typedef union packed {
        kyber_pair_t kyber;
        dcoef_t      dil;
    } op_word_u;

    // request beat
    // b unused in butterfly mode
    typedef struct packed {
        add_mode_e mode;
        op_word_u  a;
        op_word_u  b;
    } add_req_t;

    // result beat
    typedef op_word_u add_rsp_t;

endpackage

`default_nettype wire

/* rtl/mod_adder.sv */
`timescale 1ns/100ps
`default_nettype none

module mod_adder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mod_add_pkg::add_req_t req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output mod_add_pkg::add_rsp_t rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_ready
);

    // stage 1 request toward both units
    mod_add_pkg::add_req_t s1_req;

    // kyber lane pair result
    mod_add_pkg::add_rsp_t k_rsp;

    // dilithium reduced sum
    mod_add_pkg::dcoef_t   d_sum;

    // handshake and both pipeline stages
    mod_add_pipe u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .s1_req    (s1_req),
        .k_rsp     (k_rsp),
        .d_sum     (d_sum),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    // 12-bit add and subtract lanes
    kyber_lane_pair u_kyber (
        .s1_req (s1_req),
        .k_rsp  (k_rsp)
    );

    // 24-bit add on the dil views
    dilithium_add u_dil (
        .a     (s1_req.a.dil),
        .b     (s1_req.b.dil),
        .d_sum (d_sum)
    );

endmodule

`default_nettype wire

/* include/mod_adder_ref.svh */
`ifndef MOD_ADDER_REF_SVH
`define MOD_ADDER_REF_SVH

// expected result for one request
// wide integer math then a plain modulo
function automatic mod_add_pkg::add_rsp_t ref_result(input mod_add_pkg::add_req_t r);
    mod_add_pkg::add_rsp_t res;
    int unsigned           kq;
    int unsigned           dq;
    int unsigned           ah;
    int unsigned           al;
    int unsigned           bh;
    int unsigned           bl;
    kq  = mod_add_pkg::kyber_q;
    dq  = mod_add_pkg::dil_q;
    ah  = r.a.kyber.hi;
    al  = r.a.kyber.lo;
    bh  = r.b.kyber.hi;
    bl  = r.b.kyber.lo;
    res = '0;
    case (r.mode)
        mod_add_pkg::mode_k_bfly: begin
            res.kyber.hi = mod_add_pkg::coef_t'((ah + al) % kq);
            res.kyber.lo = mod_add_pkg::coef_t'((ah + kq - al) % kq);
        end
        mod_add_pkg::mode_k_cross: begin
            // subtract in the hi half
            res.kyber.hi = mod_add_pkg::coef_t'((bh + kq - ah) % kq);
            res.kyber.lo = mod_add_pkg::coef_t'((al + bl) % kq);
        end
        default: begin
            res.dil = mod_add_pkg::dcoef_t'((int'(r.a.dil) + int'(r.b.dil)) % dq);
        end
    endcase
    return res;
endfunction

// compare one result and stop on mismatch
task automatic check_value(input mod_add_pkg::add_rsp_t expected,
                           input mod_add_pkg::add_rsp_t actual,
                           input string                 msg);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, msg, expected, actual);
        $display("Errors found");
        $fatal(1);
    end
endtask

`endif

/* sim/mod_adder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mod_adder_tb;

    `include "mod_adder_ref.svh"

    logic                  clk;
    logic                  rst_n;
    mod_add_pkg::add_req_t req;
    logic                  req_valid;
    logic                  req_ready;
    mod_add_pkg::add_rsp_t rsp;
    logic                  rsp_valid;
    logic                  rsp_ready;

    // scoreboard, one entry per accepted request
    mod_add_pkg::add_req_t exp_q[$];
    int                    acc_cyc_q[$];
    bit                    thru_q[$];

    // about 700 requests at up to 4 cycles each
    int                    max_cycles;
    int                    cycles;
    bit                    took;
    bit                    bp_on;
    bit                    thru_on;
    bit                    hold_prev;
    mod_add_pkg::add_rsp_t rsp_prev;

    mod_adder dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // small integers compared through the same word type as results
    function automatic mod_add_pkg::add_rsp_t as_word(input int v);
        mod_add_pkg::add_rsp_t w;
        w.dil = mod_add_pkg::dcoef_t'(v);
        return w;
    endfunction

    function automatic mod_add_pkg::coef_t rand_coef();
        return mod_add_pkg::coef_t'($urandom % mod_add_pkg::kyber_q);
    endfunction

    function automatic mod_add_pkg::dcoef_t rand_dil();
        return mod_add_pkg::dcoef_t'($urandom % mod_add_pkg::dil_q);
    endfunction

    function automatic mod_add_pkg::add_req_t make_req(input mod_add_pkg::add_mode_e m,
                                                       input mod_add_pkg::dcoef_t    a,
                                                       input mod_add_pkg::dcoef_t    b);
        mod_add_pkg::add_req_t r;
        r.mode  = m;
        r.a.dil = a;
        r.b.dil = b;
        return r;
    endfunction

    // in-range operands for the given mode
    function automatic mod_add_pkg::add_req_t rand_req(input mod_add_pkg::add_mode_e m);
        if (m == mod_add_pkg::mode_k_bfly || m == mod_add_pkg::mode_k_cross) begin
            return make_req(m, {rand_coef(), rand_coef()}, {rand_coef(), rand_coef()});
        end else begin
            return make_req(m, rand_dil(), rand_dil());
        end
    endfunction

    // random back-pressure, else always ready
    always @(negedge clk) begin
        if (bp_on) begin
            rsp_ready <= 1'($urandom % 2);
        end else begin
            rsp_ready <= 1'b1;
        end
    end

    // hold one request until the DUT takes it
    task automatic send(input mod_add_pkg::add_req_t r);
        int waits;
        waits     = 0;
        req       = r;
        req_valid = 1'b1;
        do begin
            @(negedge clk);
            waits++;
        end while (!took);
        req_valid = 1'b0;
        // back-to-back means taken on the very next edge
        if (thru_on) begin
            check_value(as_word(1), as_word(waits), "accept delay with rsp_ready high");
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // monitor and scoreboard
    always @(posedge clk) begin
        mod_add_pkg::add_req_t head;
        int                    acc;
        bit                    thru;
        took = 1'b0;
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, responses still missing", cycles);
            $display("Errors found");
            $fatal(1);
        end else if (rst_n) begin
            // a stall needs both stages full and the output blocked
            if (!req_ready && (exp_q.size() != 2 || rsp_ready || !rsp_valid)) begin
                $display("req_ready dropped at %0t although the pipeline was not full", $time);
                $display("Errors found");
                $fatal(1);
            end
            if (hold_prev) begin
                check_value(as_word(1), as_word(rsp_valid), "rsp_valid held under stall");
                check_value(rsp_prev, rsp, "rsp held under stall");
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Response at %0t with no request outstanding", $time);
                    $display("Errors found");
                    $fatal(1);
                end else begin
                    head = exp_q.pop_front();
                    acc  = acc_cyc_q.pop_front();
                    thru = thru_q.pop_front();
                    check_value(ref_result(head), rsp, "result");
                    if (thru) begin
                        check_value(as_word(2), as_word(cycles - acc), "latency in edges");
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(req);
                acc_cyc_q.push_back(cycles);
                thru_q.push_back(thru_on);
                took = 1'b1;
            end
            hold_prev = rsp_valid && !rsp_ready;
            rsp_prev  = rsp;
        end
    end

    initial begin
        mod_add_pkg::coef_t  km1;
        mod_add_pkg::dcoef_t dm1;
        void'($urandom(84));
        km1        = mod_add_pkg::kyber_q - 12'd1;
        dm1        = mod_add_pkg::dil_q - 24'd1;
        max_cycles = 3000;
        cycles     = 0;
        took       = 1'b0;
        bp_on      = 1'b0;
        thru_on    = 1'b0;
        hold_prev  = 1'b0;
        rsp_prev   = '0;
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b1;

        // reset held for 4 cycles
        repeat (4) begin
            @(negedge clk);
            check_value(as_word(0), as_word(rsp_valid), "rsp_valid during reset");
            check_value(as_word(1), as_word(req_ready), "req_ready during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value(as_word(0), as_word(rsp_valid), "rsp_valid after reset");
        check_value(as_word(1), as_word(req_ready), "req_ready after reset");

        bp_on = 1'b1;
        // butterfly edges, both wrap directions
        send(make_req(mod_add_pkg::mode_k_bfly, {12'd0, 12'd0}, '0));
        send(make_req(mod_add_pkg::mode_k_bfly, {km1, km1}, '0));
        send(make_req(mod_add_pkg::mode_k_bfly, {km1, 12'd0}, '0));
        send(make_req(mod_add_pkg::mode_k_bfly, {12'd0, km1}, '0));
        send(make_req(mod_add_pkg::mode_k_bfly, {12'd5, 12'd5}, '0));
        send(make_req(mod_add_pkg::mode_k_bfly, {12'd10, 12'd3000}, '0));
        for (int i = 0; i < 200; i++) begin
            send(rand_req(mod_add_pkg::mode_k_bfly));
        end

        // cross edges, b.hi below a.hi and low sums at or past q
        send(make_req(mod_add_pkg::mode_k_cross, {km1, 12'd0}, {12'd0, 12'd0}));
        send(make_req(mod_add_pkg::mode_k_cross, {12'd1, km1}, {12'd0, km1}));
        send(make_req(mod_add_pkg::mode_k_cross, {12'd7, 12'd1700}, {12'd7, 12'd1629}));
        send(make_req(mod_add_pkg::mode_k_cross, {12'd0, 12'd0}, {km1, 12'd0}));
        for (int i = 0; i < 200; i++) begin
            send(rand_req(mod_add_pkg::mode_k_cross));
        end

        // dilithium edges incl. sum of exactly q and a low-half carry
        send(make_req(mod_add_pkg::mode_d_add, dm1, dm1));
        send(make_req(mod_add_pkg::mode_d_alt, dm1, 24'd1));
        send(make_req(mod_add_pkg::mode_d_add, 24'd4190208, 24'd4190209));
        send(make_req(mod_add_pkg::mode_d_add, 24'h000fff, 24'h000001));
        send(make_req(mod_add_pkg::mode_d_alt, 24'd0, 24'd0));
        for (int i = 0; i < 200; i++) begin
            if (($urandom % 2) != 0) begin
                send(rand_req(mod_add_pkg::mode_d_alt));
            end else begin
                send(rand_req(mod_add_pkg::mode_d_add));
            end
        end

        // back-to-back with the output always ready
        bp_on = 1'b0;
        repeat (2) @(negedge clk);
        drain();
        thru_on = 1'b1;
        for (int i = 0; i < 50; i++) begin
            send(rand_req(mod_add_pkg::add_mode_e'(i % 4)));
        end
        thru_on = 1'b0;
        drain();

        // mixed modes under back-pressure again
        bp_on = 1'b1;
        for (int i = 0; i < 30; i++) begin
            send(rand_req(mod_add_pkg::add_mode_e'($urandom % 4)));
        end
        drain();
        repeat (3) @(negedge clk);

        if (exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Requests left without a response: %0d", exp_q.size());
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
